// File: design/vlsu_defines.svh
// VLSU_ELENB must equal VLSU_ELEN / 8 and VLSU_ID_WIDTH must address VLSU_NR_OUTSTANDING slots
`ifndef VLSU_DEFINES_SVH
`define VLSU_DEFINES_SVH

// Data word
`define VLSU_ELEN           32
`define VLSU_ELENB          4

// Reorder buffer
`define VLSU_NR_OUTSTANDING 4
`define VLSU_ID_WIDTH       2

// Request fields
`define VLSU_VL_WIDTH       8
`define VLSU_INSN_ID_WIDTH  4

// Vector register file geometry
`define VLSU_NR_VREGS       32
`define VLSU_VELE           8

`endif

// File: design/vlsu_pkg.sv
// Types shared by all VLSU units and the bench; element width code 2'd3 is not a legal request
`include "vlsu_defines.svh"

package vlsu_pkg;

  // Element width of a vector memory instruction
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } elem_width_e;

  typedef logic [`VLSU_ELEN-1:0]          word_t;
  typedef logic [`VLSU_ELENB-1:0]         strb_t;
  typedef logic [`VLSU_VL_WIDTH-1:0]      vl_t;
  typedef logic [`VLSU_ID_WIDTH-1:0]      rob_id_t;
  typedef logic [`VLSU_INSN_ID_WIDTH-1:0] insn_id_t;

  typedef logic [$clog2(`VLSU_NR_VREGS)-1:0] vreg_t;

  // vd * VLSU_VELE + word index
  typedef logic [$clog2(`VLSU_NR_VREGS*`VLSU_VELE)-1:0] vreg_addr_t;

endpackage

// File: design/vlsu_op_if.sv
// Active instruction fields are only meaningful while active is high
`timescale 1ns/1ps
`include "vlsu_defines.svh"

interface vlsu_op_if
  import vlsu_pkg::*;
();

  logic  active;
  logic  is_load;
  word_t base_addr;
  vreg_t vd;
  vl_t   vl_bytes;
  // High in the acceptance cycle only
  logic  start;

  modport ctrl_mp (
    output active,
    output is_load,
    output base_addr,
    output vd,
    output vl_bytes,
    output start
  );

  modport unit_mp (
    input active,
    input is_load,
    input base_addr,
    input vd,
    input vl_bytes,
    input start
  );

endinterface

// File: design/vlsu_ctrl.sv
// One instruction at a time; vl times the element size must stay below 2**VLSU_VL_WIDTH
`timescale 1ns/1ps
`include "vlsu_defines.svh"

module vlsu_ctrl
  import vlsu_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  logic        req_is_load_i,
  input  elem_width_e req_ew_i,
  input  vl_t         req_vl_i,
  input  word_t       req_addr_i,
  input  vreg_t       req_vd_i,
  input  insn_id_t    req_id_i,
  input  logic        mem_done_i,
  input  logic        vreg_done_i,
  output logic        rsp_valid_o,
  output insn_id_t    rsp_id_o,
  output vreg_t       rsp_vd_o,
  vlsu_op_if.ctrl_mp  op
);

  logic     active_q;
  logic     rsp_valid_q;
  logic     is_load_q;
  word_t    addr_q;
  vreg_t    vd_q;
  insn_id_t id_q;
  vl_t      vl_bytes_q;
  vl_t      vl_bytes_d;
  logic     accept;
  logic     start;
  logic     finish;

  assign req_ready_o = ~active_q;
  assign accept      = req_valid_i & req_ready_o;
  // Zero-length requests are taken and dropped
  assign start       = accept & (req_vl_i != '0);
  assign finish      = active_q & mem_done_i & vreg_done_i;

  // Element count to byte count
  always_comb begin
    case (req_ew_i)
      EW_8:    vl_bytes_d = req_vl_i;
      EW_16:   vl_bytes_d = req_vl_i << 1;
      EW_32:   vl_bytes_d = req_vl_i << 2;
      default: vl_bytes_d = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Instruction state
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      active_q    <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= finish;
      if (start) begin
        active_q <= 1'b1;
      end else if (finish) begin
        active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      is_load_q  <= req_is_load_i;
      addr_q     <= req_addr_i;
      vd_q       <= req_vd_i;
      id_q       <= req_id_i;
      vl_bytes_q <= vl_bytes_d;
    end
  end

  // Id and vd stay put through the response cycle
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_id_o    = id_q;
  assign rsp_vd_o    = vd_q;

  assign op.active    = active_q;
  assign op.is_load   = is_load_q;
  assign op.base_addr = addr_q;
  assign op.vd        = vd_q;
  assign op.vl_bytes  = vl_bytes_q;
  assign op.start     = start;

  // Nothing new is taken while either side still moves data
  a_one_in_flight: assert property (@(posedge clk_i) disable iff (rst_i)
    !(mem_done_i && vreg_done_i) |-> !accept);

endmodule

// File: design/vlsu_byte_counter.sv
// Counts whole words from byte zero; vl_bytes must hold still while the instruction is active
`timescale 1ns/1ps
`include "vlsu_defines.svh"

module vlsu_byte_counter
  import vlsu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  vlsu_op_if.unit_mp op,
  input  logic       advance_i,
  output logic       pending_o,
  output logic       last_o,
  output strb_t      strb_o,
  output vl_t        word_idx_o
);

  localparam int unsigned WordShift = $clog2(`VLSU_ELENB);

  vl_t count_q;
  vl_t remaining;

  assign remaining  = op.vl_bytes - count_q;
  assign pending_o  = op.active & (count_q < op.vl_bytes);
  assign last_o     = pending_o & (remaining <= vl_t'(`VLSU_ELENB));
  assign word_idx_o = count_q >> WordShift;

  // Lowest remaining bytes of the current word
  always_comb begin
    for (int k = 0; k < `VLSU_ELENB; k++) begin
      strb_o[k] = remaining > vl_t'(k);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (op.start) begin
      count_q <= '0;
    end else if (advance_i) begin
      // Saturate on the short last word
      count_q <= last_o ? op.vl_bytes : count_q + vl_t'(`VLSU_ELENB);
    end
  end

  // The datapath only moves a word when this side still owes one
  a_advance_pending: assert property (@(posedge clk_i) disable iff (rst_i)
    advance_i |-> pending_o);

endmodule

// File: design/vlsu_rob.sv
// Ids are handed out in ring order; alloc_i must stay low while full_o is high
`timescale 1ns/1ps
`include "vlsu_defines.svh"

module vlsu_rob
  import vlsu_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    alloc_i,
  output rob_id_t alloc_id_o,
  output logic    full_o,
  input  logic    fill_i,
  input  rob_id_t fill_id_i,
  input  word_t   fill_data_i,
  output logic    head_valid_o,
  output word_t   head_data_o,
  input  logic    pop_i
);

  localparam int unsigned Depth = `VLSU_NR_OUTSTANDING;

  word_t            data_q [Depth];
  logic [Depth-1:0] busy_q;
  logic [Depth-1:0] filled_q;
  rob_id_t          alloc_ptr_q;
  rob_id_t          head_ptr_q;

  function automatic rob_id_t next_id(input rob_id_t id);
    return (id == rob_id_t'(Depth - 1)) ? '0 : id + rob_id_t'(1);
  endfunction

  // Ring is full when the next slot to hand out is still in use
  assign full_o       = busy_q[alloc_ptr_q];
  assign alloc_id_o   = alloc_ptr_q;
  assign head_valid_o = filled_q[head_ptr_q];
  assign head_data_o  = data_q[head_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q      <= '0;
      filled_q    <= '0;
      alloc_ptr_q <= '0;
      head_ptr_q  <= '0;
    end else begin
      if (pop_i) begin
        busy_q[head_ptr_q]   <= 1'b0;
        filled_q[head_ptr_q] <= 1'b0;
        head_ptr_q           <= next_id(head_ptr_q);
      end
      if (alloc_i) begin
        busy_q[alloc_ptr_q] <= 1'b1;
        alloc_ptr_q         <= next_id(alloc_ptr_q);
      end
      if (fill_i) begin
        filled_q[fill_id_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      data_q[fill_id_i] <= fill_data_i;
    end
  end

  // A fill lands on a slot handed out earlier or in this very cycle
  a_fill_allocated: assert property (@(posedge clk_i) disable iff (rst_i)
    fill_i |-> busy_q[fill_id_i] || (alloc_i && fill_id_i == alloc_id_o));

  a_pop_filled: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> head_valid_o);

endmodule

// File: design/vlsu_datapath.sv
// Unit-stride transfers from a word-aligned base over one memory port and one register port
`timescale 1ns/1ps
`include "vlsu_defines.svh"

module vlsu_datapath
  import vlsu_pkg::*;
(
  vlsu_op_if.unit_mp op,
  // Memory-side counter
  input  logic       mem_pending_i,
  input  logic       mem_last_i,
  input  strb_t      mem_strb_i,
  input  vl_t        mem_word_idx_i,
  output logic       mem_advance_o,
  // Register-side counter
  input  logic       vreg_pending_i,
  input  strb_t      vreg_strb_i,
  input  vl_t        vreg_word_idx_i,
  output logic       vreg_advance_o,
  // Reorder buffer
  output logic       rob_alloc_o,
  input  rob_id_t    rob_alloc_id_i,
  input  logic       rob_full_i,
  output logic       rob_fill_o,
  output rob_id_t    rob_fill_id_o,
  output word_t      rob_fill_data_o,
  input  logic       rob_head_valid_i,
  input  word_t      rob_head_data_i,
  output logic       rob_pop_o,
  // Memory port
  output logic       mem_valid_o,
  input  logic       mem_ready_i,
  output word_t      mem_addr_o,
  output logic       mem_we_o,
  output strb_t      mem_strb_o,
  output word_t      mem_wdata_o,
  output rob_id_t    mem_id_o,
  output logic       mem_last_o,
  input  logic       mem_result_valid_i,
  input  rob_id_t    mem_result_id_i,
  input  word_t      mem_result_rdata_i,
  // Register file port
  output vreg_addr_t vrf_waddr_o,
  output word_t      vrf_wdata_o,
  output logic       vrf_we_o,
  output strb_t      vrf_wbe_o,
  input  logic       vrf_wvalid_i,
  output vreg_addr_t vrf_raddr_o,
  output logic       vrf_re_o,
  input  word_t      vrf_rdata_i,
  input  logic       vrf_rvalid_i
);

  logic       mem_fire;
  logic       vrf_wfire;
  logic       vrf_rfire;
  vreg_addr_t vreg_addr;

  ////////////////////////////////////////////////////////////////////////////
  // Addressing
  assign mem_addr_o = op.base_addr + (word_t'(mem_word_idx_i) << $clog2(`VLSU_ELENB));
  assign vreg_addr  = vreg_addr_t'(op.vd) * vreg_addr_t'(`VLSU_VELE)
                    + vreg_addr_t'(vreg_word_idx_i);

  assign vrf_waddr_o = vreg_addr;
  assign vrf_raddr_o = vreg_addr;

  // Buffer head feeds whichever side drains it
  assign vrf_wdata_o = rob_head_data_i;
  assign vrf_wbe_o   = vreg_strb_i;
  assign mem_wdata_o = rob_head_data_i;
  assign mem_strb_o  = mem_strb_i;
  assign mem_last_o  = mem_last_i;
  assign mem_we_o    = ~op.is_load;

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes
  // Loads need a free slot, stores need a filled head
  assign mem_valid_o = mem_pending_i & (op.is_load ? ~rob_full_i : rob_head_valid_i);
  // Store ids simply follow the word order
  assign mem_id_o    = op.is_load ? rob_alloc_id_i : rob_id_t'(mem_word_idx_i);
  assign vrf_we_o    = op.is_load & vreg_pending_i & rob_head_valid_i;
  assign vrf_re_o    = ~op.is_load & vreg_pending_i & ~rob_full_i;

  assign mem_fire  = mem_valid_o & mem_ready_i;
  assign vrf_wfire = vrf_we_o & vrf_wvalid_i;
  assign vrf_rfire = vrf_re_o & vrf_rvalid_i;

  assign mem_advance_o  = mem_fire;
  assign vreg_advance_o = vrf_wfire | vrf_rfire;

  // Loads allocate on the memory request and stores on the register read
  assign rob_alloc_o     = op.is_load ? mem_fire : vrf_rfire;
  assign rob_fill_o      = op.is_load ? mem_result_valid_i : vrf_rfire;
  assign rob_fill_id_o   = op.is_load ? mem_result_id_i : rob_alloc_id_i;
  assign rob_fill_data_o = op.is_load ? mem_result_rdata_i : vrf_rdata_i;
  assign rob_pop_o       = op.is_load ? vrf_wfire : mem_fire;

endmodule

// File: design/vlsu_top.sv
// Base address must be word aligned and a request must fit inside its vector register
`timescale 1ns/1ps
`include "vlsu_defines.svh"

module vlsu_top (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  // Instruction request and response
  input  logic                                          req_valid_i,
  output logic                                          req_ready_o,
  input  logic                                          req_is_load_i,
  input  logic [1:0]                                    req_ew_i,
  input  logic [`VLSU_VL_WIDTH-1:0]                     req_vl_i,
  input  logic [`VLSU_ELEN-1:0]                         req_addr_i,
  input  logic [$clog2(`VLSU_NR_VREGS)-1:0]             req_vd_i,
  input  logic [`VLSU_INSN_ID_WIDTH-1:0]                req_id_i,
  output logic                                          rsp_valid_o,
  output logic [`VLSU_INSN_ID_WIDTH-1:0]                rsp_id_o,
  output logic [$clog2(`VLSU_NR_VREGS)-1:0]             rsp_vd_o,
  // Memory port
  output logic                                          mem_valid_o,
  input  logic                                          mem_ready_i,
  output logic [`VLSU_ELEN-1:0]                         mem_addr_o,
  output logic                                          mem_we_o,
  output logic [`VLSU_ELENB-1:0]                        mem_strb_o,
  output logic [`VLSU_ELEN-1:0]                         mem_wdata_o,
  output logic [`VLSU_ID_WIDTH-1:0]                     mem_id_o,
  output logic                                          mem_last_o,
  input  logic                                          mem_result_valid_i,
  input  logic [`VLSU_ID_WIDTH-1:0]                     mem_result_id_i,
  input  logic [`VLSU_ELEN-1:0]                         mem_result_rdata_i,
  // Register file port
  output logic [$clog2(`VLSU_NR_VREGS*`VLSU_VELE)-1:0] vrf_waddr_o,
  output logic [`VLSU_ELEN-1:0]                         vrf_wdata_o,
  output logic                                          vrf_we_o,
  output logic [`VLSU_ELENB-1:0]                        vrf_wbe_o,
  input  logic                                          vrf_wvalid_i,
  output logic [$clog2(`VLSU_NR_VREGS*`VLSU_VELE)-1:0] vrf_raddr_o,
  output logic                                          vrf_re_o,
  input  logic [`VLSU_ELEN-1:0]                         vrf_rdata_i,
  input  logic                                          vrf_rvalid_i
);

  logic                          mem_pending;
  logic                          mem_last;
  logic [`VLSU_ELENB-1:0]        mem_strb;
  logic [`VLSU_VL_WIDTH-1:0]     mem_word_idx;
  logic                          mem_advance;
  logic                          vreg_pending;
  logic [`VLSU_ELENB-1:0]        vreg_strb;
  logic [`VLSU_VL_WIDTH-1:0]     vreg_word_idx;
  logic                          vreg_advance;
  logic                          rob_alloc;
  logic [`VLSU_ID_WIDTH-1:0]     rob_alloc_id;
  logic                          rob_full;
  logic                          rob_fill;
  logic [`VLSU_ID_WIDTH-1:0]     rob_fill_id;
  logic [`VLSU_ELEN-1:0]         rob_fill_data;
  logic                          rob_head_valid;
  logic [`VLSU_ELEN-1:0]         rob_head_data;
  logic                          rob_pop;

  vlsu_op_if op_if0 ();

  vlsu_ctrl ctrl0 (
    .req_ew_i    (vlsu_pkg::elem_width_e'(req_ew_i)),
    .mem_done_i  (~mem_pending),
    .vreg_done_i (~vreg_pending),
    .op          (op_if0),
    .*
  );

  vlsu_byte_counter mem_cnt0 (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .op         (op_if0),
    .advance_i  (mem_advance),
    .pending_o  (mem_pending),
    .last_o     (mem_last),
    .strb_o     (mem_strb),
    .word_idx_o (mem_word_idx)
  );

  // Register side needs no last flag
  vlsu_byte_counter vreg_cnt0 (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .op         (op_if0),
    .advance_i  (vreg_advance),
    .pending_o  (vreg_pending),
    .last_o     (),
    .strb_o     (vreg_strb),
    .word_idx_o (vreg_word_idx)
  );

  vlsu_rob rob0 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .alloc_i      (rob_alloc),
    .alloc_id_o   (rob_alloc_id),
    .full_o       (rob_full),
    .fill_i       (rob_fill),
    .fill_id_i    (rob_fill_id),
    .fill_data_i  (rob_fill_data),
    .head_valid_o (rob_head_valid),
    .head_data_o  (rob_head_data),
    .pop_i        (rob_pop)
  );

  // Memory and register file ports connect by name
  vlsu_datapath datapath0 (
    .op               (op_if0),
    .mem_pending_i    (mem_pending),
    .mem_last_i       (mem_last),
    .mem_strb_i       (mem_strb),
    .mem_word_idx_i   (mem_word_idx),
    .mem_advance_o    (mem_advance),
    .vreg_pending_i   (vreg_pending),
    .vreg_strb_i      (vreg_strb),
    .vreg_word_idx_i  (vreg_word_idx),
    .vreg_advance_o   (vreg_advance),
    .rob_alloc_o      (rob_alloc),
    .rob_alloc_id_i   (rob_alloc_id),
    .rob_full_i       (rob_full),
    .rob_fill_o       (rob_fill),
    .rob_fill_id_o    (rob_fill_id),
    .rob_fill_data_o  (rob_fill_data),
    .rob_head_valid_i (rob_head_valid),
    .rob_head_data_i  (rob_head_data),
    .rob_pop_o        (rob_pop),
    .*
  );

endmodule

// File: bench/vlsu_mem_model.sv
// Word memory of MemWords words, addresses wrap; at most one load result per cycle
`timescale 1ns/1ps
`include "vlsu_defines.svh"

module vlsu_mem_model
  import vlsu_pkg::*;
#(
  parameter int unsigned MemWords = 256,
  parameter logic [31:0] Seed     = 32'h922af316
) (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    stress_i,
  input  logic    mem_valid_i,
  output logic    mem_ready_o,
  input  word_t   mem_addr_i,
  input  logic    mem_we_i,
  input  strb_t   mem_strb_i,
  input  word_t   mem_wdata_i,
  input  rob_id_t mem_id_i,
  output logic    result_valid_o,
  output rob_id_t result_id_o,
  output word_t   result_rdata_o
);

  localparam int unsigned IdxW = $clog2(MemWords);

  word_t mem_words [MemWords];
  // Outstanding load results as {id, data}
  logic [`VLSU_ID_WIDTH+`VLSU_ELEN-1:0] pend_q [$];

  logic            ready_q  = 1'b0;
  logic            rvalid_q = 1'b0;
  rob_id_t         rid_q    = '0;
  word_t           rdata_q  = '0;
  integer          seed     = Seed;
  logic [31:0]     rnd;
  int              pick;
  logic [IdxW-1:0] idx;

  assign mem_ready_o    = ready_q;
  assign result_valid_o = rvalid_q;
  assign result_id_o    = rid_q;
  assign result_rdata_o = rdata_q;

  always @(posedge clk_i) begin
    rnd = $random(seed);
    if (rst_i) begin
      for (int i = 0; i < MemWords; i++) begin
        mem_words[i] <= (word_t'(i) * 32'h9e3779b1) ^ 32'h0f1e2d3c;
      end
      pend_q.delete();
      ready_q  <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      idx = mem_addr_i[IdxW+1:2];
      if (mem_valid_i && ready_q) begin
        if (mem_we_i) begin
          for (int b = 0; b < `VLSU_ELENB; b++) begin
            if (mem_strb_i[b]) begin
              mem_words[idx][8*b +: 8] <= mem_wdata_i[8*b +: 8];
            end
          end
        end else begin
          pend_q.push_back({mem_id_i, mem_words[idx]});
        end
      end

      // Plain mode answers oldest first
      // Stressed mode waits until no request is offered, then answers newest first
      pick = -1;
      if (pend_q.size() != 0) begin
        if (!stress_i) begin
          pick = 0;
        end else if (!mem_valid_i && rnd[0]) begin
          pick = pend_q.size() - 1;
        end
      end
      rvalid_q <= (pick >= 0);
      if (pick >= 0) begin
        {rid_q, rdata_q} <= pend_q[pick];
        pend_q.delete(pick);
      end

      ready_q <= stress_i ? (rnd[2:1] != 2'b00) : 1'b1;
    end
  end

endmodule

// File: bench/tb_vlsu.sv
// Directed VLSU tests; all transfers stay inside the first 256 memory words
`timescale 1ns/1ps
`include "vlsu_defines.svh"

module tb_vlsu
  import vlsu_pkg::*;
();

  localparam int unsigned ResetCycles = 4;
  localparam int unsigned NumTests    = 6;
  localparam int unsigned CycleLimit  = NumTests * 200 + ResetCycles;
  localparam int unsigned VrfWords    = `VLSU_NR_VREGS * `VLSU_VELE;
  localparam int unsigned MemWords    = 256;
  localparam logic [31:0] Seed        = 32'h922af316;

  logic       clk_i         = 1'b0;
  logic       rst_i         = 1'b1;
  logic       req_valid_i   = 1'b0;
  logic       req_ready_o;
  logic       req_is_load_i = 1'b0;
  logic [1:0] req_ew_i      = 2'd0;
  vl_t        req_vl_i      = '0;
  word_t      req_addr_i    = '0;
  vreg_t      req_vd_i      = '0;
  insn_id_t   req_id_i      = '0;
  logic       rsp_valid_o;
  insn_id_t   rsp_id_o;
  vreg_t      rsp_vd_o;
  logic       mem_valid_o;
  logic       mem_ready_i;
  word_t      mem_addr_o;
  logic       mem_we_o;
  strb_t      mem_strb_o;
  word_t      mem_wdata_o;
  rob_id_t    mem_id_o;
  logic       mem_last_o;
  logic       mem_result_valid_i;
  rob_id_t    mem_result_id_i;
  word_t      mem_result_rdata_i;
  vreg_addr_t vrf_waddr_o;
  word_t      vrf_wdata_o;
  logic       vrf_we_o;
  strb_t      vrf_wbe_o;
  logic       vrf_wvalid_i  = 1'b0;
  vreg_addr_t vrf_raddr_o;
  logic       vrf_re_o;
  word_t      vrf_rdata_i;
  logic       vrf_rvalid_i  = 1'b0;
  logic       stress        = 1'b0;

  // Instruction under test and the state before it started
  logic        exp_is_load = 1'b0;
  elem_width_e exp_ew      = EW_8;
  vl_t         exp_vl      = '0;
  word_t       exp_addr    = '0;
  vreg_t       exp_vd      = '0;
  insn_id_t    exp_id      = '0;
  word_t       vrf_before [VrfWords];
  word_t       mem_before [MemWords];

  word_t       vrf [VrfWords];
  integer      seed = Seed;
  logic [31:0] rnd;

  int unsigned cycle_count   = 0;
  int unsigned mem_req_count = 0;
  int unsigned vrf_wr_count  = 0;
  int unsigned vrf_rd_count  = 0;
  int unsigned rsp_count     = 0;
  int unsigned mon_errors    = 0;
  int unsigned chk_errors    = 0;
  int unsigned seq_errors    = 0;
  int unsigned tests_run     = 0;
  int unsigned tests_passed  = 0;
  int          mem_next      = 0;
  int          wr_next       = 0;
  int          rd_next       = 0;
  word_t       mon_addr;
  vreg_addr_t  mon_vaddr;
  strb_t       mon_strb;
  logic        mon_last;
  int          chk_k;
  int          chk_base;
  word_t       chk_exp;

  vlsu_top dut0 (.*);

  vlsu_mem_model #(
    .MemWords (MemWords),
    .Seed     (Seed)
  ) mem0 (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .stress_i       (stress),
    .mem_valid_i    (mem_valid_o),
    .mem_ready_o    (mem_ready_i),
    .mem_addr_i     (mem_addr_o),
    .mem_we_i       (mem_we_o),
    .mem_strb_i     (mem_strb_o),
    .mem_wdata_i    (mem_wdata_o),
    .mem_id_i       (mem_id_o),
    .result_valid_o (mem_result_valid_i),
    .result_id_o    (mem_result_id_i),
    .result_rdata_o (mem_result_rdata_i)
  );

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  // Byte enables of word k for vl elements of width ew
  function automatic strb_t ref_strb(input vl_t vl, input elem_width_e ew, input int k);
    int    nbytes;
    strb_t strb;
    case (ew)
      EW_8:    nbytes = int'(vl);
      EW_16:   nbytes = int'(vl) * 2;
      default: nbytes = int'(vl) * 4;
    endcase
    for (int b = 0; b < `VLSU_ELENB; b++) begin
      strb[b] = (k * `VLSU_ELENB + b) < nbytes;
    end
    return strb;
  endfunction

  // Destination word k after the transfer
  function automatic word_t expected_word(input word_t old_w, input word_t src_w,
                                          input vl_t vl, input elem_width_e ew, input int k);
    strb_t strb;
    word_t w;
    strb = ref_strb(vl, ew, k);
    w    = old_w;
    for (int b = 0; b < `VLSU_ELENB; b++) begin
      if (strb[b]) begin
        w[8*b +: 8] = src_w[8*b +: 8];
      end
    end
    return w;
  endfunction

  function automatic int unsigned total_errors();
    return mon_errors + chk_errors + seq_errors;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Register file model with read data following the read address
  assign vrf_rdata_i = vrf[vrf_raddr_o];

  always @(posedge clk_i) begin
    rnd = $random(seed);
    if (rst_i) begin
      for (int a = 0; a < VrfWords; a++) begin
        vrf[a] <= (word_t'(a) * 32'h01000193) ^ 32'hc3a50000;
      end
      vrf_wvalid_i <= 1'b0;
      vrf_rvalid_i <= 1'b0;
    end else begin
      vrf_wvalid_i <= (rnd[1:0] != 2'b00);
      vrf_rvalid_i <= (rnd[3:2] != 2'b00);
      if (vrf_we_o && vrf_wvalid_i) begin
        for (int b = 0; b < `VLSU_ELENB; b++) begin
          if (vrf_wbe_o[b]) begin
            vrf[vrf_waddr_o][8*b +: 8] <= vrf_wdata_o[8*b +: 8];
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= CycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("** FAIL **");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Beat monitor for addresses, strobes and the last flag in program order
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (req_valid_i && req_ready_o) begin
        mem_next = 0;
        wr_next  = 0;
        rd_next  = 0;
      end
      if (mem_valid_o && mem_ready_i) begin
        mem_req_count++;
        mon_addr = exp_addr + word_t'(mem_next * `VLSU_ELENB);
        mon_strb = ref_strb(exp_vl, exp_ew, mem_next);
        mon_last = (ref_strb(exp_vl, exp_ew, mem_next + 1) == '0);
        if (mem_addr_o !== mon_addr) begin
          $display("MISMATCH mem_addr_o: expected 0x%h, got 0x%h", mon_addr, mem_addr_o);
          mon_errors++;
        end
        if (mem_we_o !== !exp_is_load) begin
          $display("MISMATCH mem_we_o: expected 0x%h, got 0x%h", !exp_is_load, mem_we_o);
          mon_errors++;
        end
        if (mem_strb_o !== mon_strb) begin
          $display("MISMATCH mem_strb_o: expected 0x%h, got 0x%h", mon_strb, mem_strb_o);
          mon_errors++;
        end
        if (mem_last_o !== mon_last) begin
          $display("MISMATCH mem_last_o: expected 0x%h, got 0x%h", mon_last, mem_last_o);
          mon_errors++;
        end
        mem_next++;
      end
      if (vrf_we_o && vrf_wvalid_i) begin
        vrf_wr_count++;
        mon_vaddr = vreg_addr_t'(int'(exp_vd) * `VLSU_VELE + wr_next);
        mon_strb  = ref_strb(exp_vl, exp_ew, wr_next);
        if (vrf_waddr_o !== mon_vaddr) begin
          $display("MISMATCH vrf_waddr_o: expected 0x%h, got 0x%h", mon_vaddr, vrf_waddr_o);
          mon_errors++;
        end
        if (vrf_wbe_o !== mon_strb) begin
          $display("MISMATCH vrf_wbe_o: expected 0x%h, got 0x%h", mon_strb, vrf_wbe_o);
          mon_errors++;
        end
        wr_next++;
      end
      if (vrf_re_o && vrf_rvalid_i) begin
        vrf_rd_count++;
        mon_vaddr = vreg_addr_t'(int'(exp_vd) * `VLSU_VELE + rd_next);
        if (vrf_raddr_o !== mon_vaddr) begin
          $display("MISMATCH vrf_raddr_o: expected 0x%h, got 0x%h", mon_vaddr, vrf_raddr_o);
          mon_errors++;
        end
        rd_next++;
      end
    end
  end

  // Final state checked on the falling edge after each response
  always @(negedge clk_i) begin
    if (!rst_i && rsp_valid_o) begin
      rsp_count++;
      if (rsp_id_o !== exp_id) begin
        $display("MISMATCH rsp_id_o: expected 0x%h, got 0x%h", exp_id, rsp_id_o);
        chk_errors++;
      end
      if (rsp_vd_o !== exp_vd) begin
        $display("MISMATCH rsp_vd_o: expected 0x%h, got 0x%h", exp_vd, rsp_vd_o);
        chk_errors++;
      end
      chk_base = int'(exp_addr >> 2);
      for (int a = 0; a < VrfWords; a++) begin
        chk_k   = a - int'(exp_vd) * `VLSU_VELE;
        chk_exp = vrf_before[a];
        if (exp_is_load && chk_k >= 0 && chk_k < `VLSU_VELE) begin
          chk_exp = expected_word(vrf_before[a], mem_before[chk_base + chk_k],
                                  exp_vl, exp_ew, chk_k);
        end
        if (vrf[a] !== chk_exp) begin
          $display("MISMATCH vrf[0x%0h]: expected 0x%h, got 0x%h", a, chk_exp, vrf[a]);
          chk_errors++;
        end
      end
      for (int m = 0; m < MemWords; m++) begin
        chk_k   = m - chk_base;
        chk_exp = mem_before[m];
        if (!exp_is_load && chk_k >= 0 && chk_k < `VLSU_VELE) begin
          chk_exp = expected_word(mem_before[m],
                                  vrf_before[int'(exp_vd) * `VLSU_VELE + chk_k],
                                  exp_vl, exp_ew, chk_k);
        end
        if (mem0.mem_words[m] !== chk_exp) begin
          $display("MISMATCH mem[0x%0h]: expected 0x%h, got 0x%h",
                   m, chk_exp, mem0.mem_words[m]);
          chk_errors++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  task automatic run_op(input string name, input logic is_load, input elem_width_e ew,
                        input vl_t vl, input word_t addr, input vreg_t vd, input insn_id_t id);
    int unsigned err_before;
    int unsigned rsp_before;
    int unsigned traffic_before;
    err_before     = total_errors();
    rsp_before     = rsp_count;
    traffic_before = mem_req_count + vrf_wr_count + vrf_rd_count;
    for (int a = 0; a < VrfWords; a++) begin
      vrf_before[a] = vrf[a];
    end
    for (int m = 0; m < MemWords; m++) begin
      mem_before[m] = mem0.mem_words[m];
    end
    exp_is_load = is_load;
    exp_ew      = ew;
    exp_vl      = vl;
    exp_addr    = addr;
    exp_vd      = vd;
    exp_id      = id;

    req_valid_i   <= 1'b1;
    req_is_load_i <= is_load;
    req_ew_i      <= ew;
    req_vl_i      <= vl;
    req_addr_i    <= addr;
    req_vd_i      <= vd;
    req_id_i      <= id;
    do begin
      @(posedge clk_i);
    end while (!req_ready_o);
    req_valid_i <= 1'b0;

    if (vl != '0) begin
      while (rsp_count == rsp_before) begin
        @(posedge clk_i);
      end
      // Window for a stray second pulse
      repeat (5) @(posedge clk_i);
      if (rsp_count - rsp_before != 1) begin
        $display("%s: %0d responses seen where one was expected", name, rsp_count - rsp_before);
        seq_errors++;
      end
    end else begin
      repeat (20) begin
        @(posedge clk_i);
        if (!req_ready_o) begin
          $display("%s: req_ready_o dropped after a zero-length request", name);
          seq_errors++;
        end
      end
      if (mem_req_count + vrf_wr_count + vrf_rd_count != traffic_before) begin
        $display("%s: memory or register-file traffic on a zero-length request", name);
        seq_errors++;
      end
      if (rsp_count != rsp_before) begin
        $display("%s: a zero-length request produced a response", name);
        seq_errors++;
      end
    end

    tests_run++;
    if (total_errors() == err_before) begin
      tests_passed++;
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", tests_run, name,
               total_errors() - err_before);
    end
  endtask

  initial begin
    repeat (ResetCycles) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);

    run_op("load ew32 vl8", 1'b1, EW_32, 8'd8, 32'h0000_0100, 5'd3, 4'd1);
    run_op("load ew8 vl7", 1'b1, EW_8, 8'd7, 32'h0000_0140, 5'd4, 4'd2);
    run_op("store ew16 vl5", 1'b0, EW_16, 8'd5, 32'h0000_0200, 5'd6, 4'd3);

    // Random ready, held and reversed load results
    stress <= 1'b1;
    run_op("stressed load ew32 vl8", 1'b1, EW_32, 8'd8, 32'h0000_0100, 5'd9, 4'd4);
    run_op("stressed store ew8 vl30", 1'b0, EW_8, 8'd30, 32'h0000_0300, 5'd10, 4'd5);
    stress <= 1'b0;

    run_op("zero-length load", 1'b1, EW_32, 8'd0, 32'h0000_0100, 5'd7, 4'd6);

    $display("tests run %0d, passed %0d, errors %0d", tests_run, tests_passed, total_errors());
    if (total_errors() == 0 && tests_passed == NumTests) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+design
design/vlsu_pkg.sv
design/vlsu_op_if.sv
design/vlsu_ctrl.sv
design/vlsu_byte_counter.sv
design/vlsu_rob.sv
design/vlsu_datapath.sv
design/vlsu_top.sv
bench/vlsu_mem_model.sv
bench/tb_vlsu.sv

// File: run.sh
#!/usr/bin/env bash
# Build the VLSU testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_vlsu \
  -Mdir "$BUILD_DIR" -o Vtb_vlsu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_vlsu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qxF "** PASS **" "$LOG"; then
  exit 0
fi
exit 1
